/* src/corebus_pkg.sv */
`default_nettype none

package corebus_pkg;

  // ##############################
  // widths and address map
  // ##############################
  localparam int ADDR_WIDTH      = 16;
  localparam int DATA_WIDTH      = 32;
  localparam int ID_WIDTH        = 4;
  localparam int LEN_WIDTH       = 3;   // beats minus one
  localparam int SRAM_DEPTH      = 64;
  localparam int SRAM_ADDR_WIDTH = $clog2(SRAM_DEPTH);

  localparam logic [DATA_WIDTH-1:0] ERROR_DATA = 32'hdead_beaf;

  // ##############################
  // encodings
  // ##############################
  typedef enum logic [1:0] {
    CMD_READ     = 2'd0,
    CMD_WRITE    = 2'd1,  // posted
    CMD_WRITE_NP = 2'd2,
    CMD_MESSAGE  = 2'd3   // posted, no data
  } corebus_cmd_e;

  typedef enum logic {
    RESP_PLAIN = 1'b0,
    RESP_DATA  = 1'b1
  } corebus_resp_e;

  typedef struct packed {
    corebus_cmd_e          kind;
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } corebus_cmd_t;

  typedef struct packed {
    corebus_resp_e         kind;
    logic [ID_WIDTH-1:0]   id;
    logic                  error;
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } corebus_resp_t;

  // commands that are followed by write data beats
  function automatic logic has_wdata(corebus_cmd_e kind);
    return (kind == CMD_WRITE) || (kind == CMD_WRITE_NP);
  endfunction

  // commands that the target has to answer
  function automatic logic needs_resp(corebus_cmd_e kind);
    return (kind == CMD_READ) || (kind == CMD_WRITE_NP);
  endfunction

endpackage

`default_nettype wire

/* src/corebus_if.sv */
`default_nettype none

interface corebus_if
  import corebus_pkg::*;
();
  logic                  cmd_valid;
  logic                  cmd_accept;
  corebus_cmd_t          cmd;

  logic                  wdata_valid;
  logic                  wdata_accept;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  wdata_last;

  logic                  resp_valid;
  logic                  resp_accept;
  corebus_resp_t         resp;

  modport cmd_master (
    output cmd_valid, cmd,
    input  cmd_accept,
    output wdata_valid, wdata, wdata_last,
    input  wdata_accept
  );

  modport resp_master (
    input  resp_valid, resp,
    output resp_accept
  );

  modport slave (
    input  cmd_valid, cmd,
    output cmd_accept,
    input  wdata_valid, wdata, wdata_last,
    output wdata_accept,
    output resp_valid, resp,
    input  resp_accept
  );

endinterface

`default_nettype wire

/* src/corebus_slicer.sv */
`default_nettype none

module corebus_slicer #(
  parameter type payload_t = logic
)(
  input  var logic     i_clk,
  input  var logic     i_rst_n,
  input  var logic     i_valid,
  output logic         o_accept,
  input  var payload_t i_payload,
  output logic         o_valid,
  input  var logic     i_accept,
  output payload_t     o_payload
);
  logic     valid_q;
  payload_t payload_q;
  logic     load;

  // take a new entry when empty or when the held one leaves this cycle
  assign o_accept  = !valid_q || i_accept;
  assign load      = i_valid && o_accept;
  assign o_valid   = valid_q;
  assign o_payload = payload_q;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end
    else if (o_accept) begin
      valid_q <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      payload_q <= i_payload;
    end
  end

endmodule

`default_nettype wire

/* src/corebus_decoder.sv */
`default_nettype none

module corebus_decoder
  import corebus_pkg::*;
(
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  input  var logic                  i_cmd_valid,
  output logic                      o_cmd_accept,
  input  var corebus_cmd_t          i_cmd,
  input  var logic                  i_wdata_valid,
  output logic                      o_wdata_accept,
  input  var logic [DATA_WIDTH-1:0] i_wdata,
  input  var logic                  i_wdata_last,
  input  var logic                  i_resp_done,
  corebus_if.cmd_master             sram_if,
  corebus_if.cmd_master             dummy_if
);
  logic sel_sram;
  logic busy;
  logic wait_resp;    // busy until the last response beat leaves the top
  logic data_active;
  logic data_sram;    // write data goes to the memory
  logic cmd_fire;
  logic wdata_last_fire;

  // ##############################
  // command routing
  // ##############################
  assign sel_sram = i_cmd.addr < ADDR_WIDTH'(SRAM_DEPTH);

  assign sram_if.cmd_valid  = i_cmd_valid && !busy && sel_sram;
  assign sram_if.cmd        = i_cmd;
  assign dummy_if.cmd_valid = i_cmd_valid && !busy && !sel_sram;
  assign dummy_if.cmd       = i_cmd;

  assign o_cmd_accept = !busy && (sel_sram ? sram_if.cmd_accept : dummy_if.cmd_accept);
  assign cmd_fire     = i_cmd_valid && o_cmd_accept;

  // ##############################
  // write data routing
  // ##############################
  assign sram_if.wdata_valid  = i_wdata_valid && data_active && data_sram;
  assign sram_if.wdata        = i_wdata;
  assign sram_if.wdata_last   = i_wdata_last;
  assign dummy_if.wdata_valid = i_wdata_valid && data_active && !data_sram;
  assign dummy_if.wdata       = i_wdata;
  assign dummy_if.wdata_last  = i_wdata_last;

  assign o_wdata_accept = data_active &&
                          (data_sram ? sram_if.wdata_accept : dummy_if.wdata_accept);
  assign wdata_last_fire = i_wdata_valid && o_wdata_accept && i_wdata_last;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      data_active <= 1'b0;
      data_sram   <= 1'b0;
    end
    else if (cmd_fire) begin
      data_active <= has_wdata(i_cmd.kind);
      data_sram   <= sel_sram;
    end
    else if (wdata_last_fire) begin
      data_active <= 1'b0;
    end
  end

  // a message never blocks the next command
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy      <= 1'b0;
      wait_resp <= 1'b0;
    end
    else if (cmd_fire) begin
      busy      <= i_cmd.kind != CMD_MESSAGE;
      wait_resp <= needs_resp(i_cmd.kind);
    end
    else if (busy && (wait_resp ? i_resp_done : wdata_last_fire)) begin
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/corebus_sram_target.sv */
`default_nettype none

module corebus_sram_target
  import corebus_pkg::*;
(
  input  var logic i_clk,
  input  var logic i_rst_n,
  corebus_if.slave bus_if
);
  logic [DATA_WIDTH-1:0]      mem [SRAM_DEPTH];
  logic [SRAM_ADDR_WIDTH-1:0] addr_q;
  logic [SRAM_ADDR_WIDTH-1:0] cmd_addr;
  logic [LEN_WIDTH-1:0]       count_q;   // read beats still to come after the current one
  logic                       wr_active;
  logic                       np_q;
  logic                       resp_valid_q;
  corebus_resp_t              resp_q;
  logic                       cmd_fire;
  logic                       is_read;
  logic                       wdata_fire;
  logic                       wr_done;
  logic                       resp_fire;

  assign bus_if.cmd_accept   = !wr_active && !resp_valid_q;
  assign bus_if.wdata_accept = wr_active;
  assign bus_if.resp_valid   = resp_valid_q;
  assign bus_if.resp         = resp_q;

  assign cmd_addr   = bus_if.cmd.addr[SRAM_ADDR_WIDTH-1:0];
  assign is_read    = bus_if.cmd.kind == CMD_READ;
  assign cmd_fire   = bus_if.cmd_valid && bus_if.cmd_accept;
  assign wdata_fire = bus_if.wdata_valid && bus_if.wdata_accept;
  assign wr_done    = wdata_fire && bus_if.wdata_last;
  assign resp_fire  = resp_valid_q && bus_if.resp_accept;

  // ##############################
  // control
  // ##############################
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_active    <= 1'b0;
      np_q         <= 1'b0;
      resp_valid_q <= 1'b0;
      count_q      <= '0;
    end
    else if (cmd_fire) begin
      wr_active    <= has_wdata(bus_if.cmd.kind);
      np_q         <= bus_if.cmd.kind == CMD_WRITE_NP;
      resp_valid_q <= is_read;
      count_q      <= bus_if.cmd.len;
    end
    else if (wr_done) begin
      wr_active    <= 1'b0;
      resp_valid_q <= np_q;  // only a non-posted write is answered
    end
    else if (resp_fire) begin
      resp_valid_q <= !resp_q.last;
      count_q      <= count_q - 1'b1;
    end
  end

  // ##############################
  // memory and response beat
  // ##############################
  always_ff @(posedge i_clk) begin
    if (cmd_fire) begin
      addr_q       <= is_read ? cmd_addr + 1'b1 : cmd_addr;
      resp_q.kind  <= RESP_DATA;
      resp_q.id    <= bus_if.cmd.id;
      resp_q.error <= 1'b0;
      resp_q.data  <= mem[cmd_addr];
      resp_q.last  <= bus_if.cmd.len == '0;
    end
    else if (wdata_fire) begin
      mem[addr_q] <= bus_if.wdata;
      addr_q      <= addr_q + 1'b1;   // wraps at the end of the memory
      if (bus_if.wdata_last) begin
        resp_q.kind <= RESP_PLAIN;
        resp_q.data <= '0;
        resp_q.last <= 1'b1;
      end
    end
    else if (resp_fire && !resp_q.last) begin
      resp_q.data <= mem[addr_q];
      resp_q.last <= count_q == LEN_WIDTH'(1);
      addr_q      <= addr_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/corebus_dummy_target.sv */
`default_nettype none

module corebus_dummy_target
  import corebus_pkg::*;
(
  input  var logic i_clk,
  input  var logic i_rst_n,
  corebus_if.slave bus_if
);
  logic                 data_phase;
  logic                 resp_pend;     // non-posted write waiting for its last data beat
  logic                 resp_valid_q;
  logic [LEN_WIDTH-1:0] count_q;       // beats left after the current one
  corebus_resp_e        kind_q;
  logic [ID_WIDTH-1:0]  id_q;
  logic                 is_read;
  logic                 cmd_fire;
  logic                 wdata_last_fire;
  logic                 resp_fire;

  assign bus_if.cmd_accept   = !data_phase && !resp_valid_q;
  assign bus_if.wdata_accept = data_phase;
  assign bus_if.resp_valid   = resp_valid_q;

  // every answer is an error and read beats carry the fixed pattern
  assign bus_if.resp = '{
    kind:  kind_q,
    id:    id_q,
    error: 1'b1,
    data:  ERROR_DATA,
    last:  count_q == '0
  };

  assign is_read         = bus_if.cmd.kind == CMD_READ;
  assign cmd_fire        = bus_if.cmd_valid && bus_if.cmd_accept;
  assign wdata_last_fire = bus_if.wdata_valid && bus_if.wdata_accept && bus_if.wdata_last;
  assign resp_fire       = resp_valid_q && bus_if.resp_accept;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      data_phase   <= 1'b0;
      resp_pend    <= 1'b0;
      resp_valid_q <= 1'b0;
      count_q      <= '0;
    end
    else if (cmd_fire) begin
      data_phase   <= has_wdata(bus_if.cmd.kind);
      resp_pend    <= bus_if.cmd.kind == CMD_WRITE_NP;
      resp_valid_q <= is_read;
      count_q      <= is_read ? bus_if.cmd.len : '0;
    end
    else if (wdata_last_fire) begin
      data_phase   <= 1'b0;
      resp_pend    <= 1'b0;
      resp_valid_q <= resp_pend;
    end
    else if (resp_fire) begin
      resp_valid_q <= count_q != '0;
      count_q      <= count_q - 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_fire) begin
      kind_q <= is_read ? RESP_DATA : RESP_PLAIN;
      id_q   <= bus_if.cmd.id;
    end
  end

endmodule

`default_nettype wire

/* src/corebus_response_mux.sv */
`default_nettype none

module corebus_response_mux
  import corebus_pkg::*;
(
  input  var logic       i_clk,
  input  var logic       i_rst_n,
  corebus_if.resp_master sram_if,
  corebus_if.resp_master dummy_if,
  output logic           o_resp_valid,
  input  var logic       i_resp_accept,
  output corebus_resp_t  o_resp,
  output logic           o_resp_done
);
  logic          mux_valid;
  logic          mux_accept;
  corebus_resp_t mux_resp;

  // the decoder lets only one target hold a response at a time
  assign mux_valid = sram_if.resp_valid || dummy_if.resp_valid;
  assign mux_resp  = sram_if.resp_valid ? sram_if.resp : dummy_if.resp;

  assign sram_if.resp_accept  = mux_accept && sram_if.resp_valid;
  assign dummy_if.resp_accept = mux_accept && dummy_if.resp_valid;

  corebus_slicer #(
    .payload_t (corebus_resp_t)
  ) u_resp_slicer (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_valid   (mux_valid),
    .o_accept  (mux_accept),
    .i_payload (mux_resp),
    .o_valid   (o_resp_valid),
    .i_accept  (i_resp_accept),
    .o_payload (o_resp)
  );

  assign o_resp_done = o_resp_valid && i_resp_accept && o_resp.last;  // ends the transaction

endmodule

`default_nettype wire

/* src/corebus_subsystem.sv */
`default_nettype none

module corebus_subsystem
  import corebus_pkg::*;
(
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  input  var logic                  i_cmd_valid,
  output logic                      o_cmd_accept,
  input  var logic [1:0]            i_cmd_kind,
  input  var logic [ID_WIDTH-1:0]   i_cmd_id,
  input  var logic [ADDR_WIDTH-1:0] i_cmd_addr,
  input  var logic [LEN_WIDTH-1:0]  i_cmd_len,
  input  var logic                  i_wdata_valid,
  output logic                      o_wdata_accept,
  input  var logic [DATA_WIDTH-1:0] i_wdata,
  input  var logic                  i_wdata_last,
  output logic                      o_resp_valid,
  input  var logic                  i_resp_accept,
  output logic                      o_resp_kind,
  output logic [ID_WIDTH-1:0]       o_resp_id,
  output logic                      o_resp_error,
  output logic [DATA_WIDTH-1:0]     o_resp_data,
  output logic                      o_resp_last
);
  corebus_cmd_t  top_cmd;
  corebus_cmd_t  slice_cmd;
  logic          slice_cmd_valid;
  logic          slice_cmd_accept;
  logic          resp_done;
  corebus_resp_t resp;

  corebus_if u_sram_bus ();
  corebus_if u_dummy_bus ();

  assign top_cmd.kind = corebus_cmd_e'(i_cmd_kind);
  assign top_cmd.id   = i_cmd_id;
  assign top_cmd.addr = i_cmd_addr;
  assign top_cmd.len  = i_cmd_len;

  corebus_slicer #(
    .payload_t (corebus_cmd_t)
  ) u_cmd_slicer (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_valid   (i_cmd_valid),
    .o_accept  (o_cmd_accept),
    .i_payload (top_cmd),
    .o_valid   (slice_cmd_valid),
    .i_accept  (slice_cmd_accept),
    .o_payload (slice_cmd)
  );

  corebus_decoder u_decoder (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_cmd_valid    (slice_cmd_valid),
    .o_cmd_accept   (slice_cmd_accept),
    .i_cmd          (slice_cmd),
    .i_wdata_valid  (i_wdata_valid),
    .o_wdata_accept (o_wdata_accept),
    .i_wdata        (i_wdata),
    .i_wdata_last   (i_wdata_last),
    .i_resp_done    (resp_done),
    .sram_if        (u_sram_bus),
    .dummy_if       (u_dummy_bus)
  );

  corebus_sram_target u_sram (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .bus_if  (u_sram_bus)
  );

  corebus_dummy_target u_dummy (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .bus_if  (u_dummy_bus)
  );

  corebus_response_mux u_resp_mux (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .sram_if       (u_sram_bus),
    .dummy_if      (u_dummy_bus),
    .o_resp_valid  (o_resp_valid),
    .i_resp_accept (i_resp_accept),
    .o_resp        (resp),
    .o_resp_done   (resp_done)
  );

  assign o_resp_kind  = resp.kind;
  assign o_resp_id    = resp.id;
  assign o_resp_error = resp.error;
  assign o_resp_data  = resp.data;
  assign o_resp_last  = resp.last;

endmodule

`default_nettype wire

/* test/tb_corebus_subsystem.sv */
`default_nettype none

module tb_corebus_subsystem
  import corebus_pkg::*;
();
  localparam int TIMEOUT = 200;  // cycles that any single wait may take

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  cmd_valid;
  logic                  cmd_accept;
  logic [1:0]            cmd_kind;
  logic [ID_WIDTH-1:0]   cmd_id;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [LEN_WIDTH-1:0]  cmd_len;
  logic                  wdata_valid;
  logic                  wdata_accept;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  wdata_last;
  logic                  resp_valid;
  logic                  resp_accept;
  logic                  resp_kind;
  logic [ID_WIDTH-1:0]   resp_id;
  logic                  resp_error;
  logic [DATA_WIDTH-1:0] resp_data;
  logic                  resp_last;

  int seed   = 31852;
  int errors = 0;

  logic [DATA_WIDTH-1:0] ref_mem [SRAM_DEPTH];  // expected memory contents
  logic [DATA_WIDTH-1:0] wr_buf  [8];

  // beats captured by collect_response
  logic                  got_kind [8];
  logic [ID_WIDTH-1:0]   got_id   [8];
  logic                  got_err  [8];
  logic [DATA_WIDTH-1:0] got_data [8];
  logic                  got_last [8];
  int                    n_got;

  always #10 clk = ~clk;

  corebus_subsystem u_dut (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_cmd_valid    (cmd_valid),
    .o_cmd_accept   (cmd_accept),
    .i_cmd_kind     (cmd_kind),
    .i_cmd_id       (cmd_id),
    .i_cmd_addr     (cmd_addr),
    .i_cmd_len      (cmd_len),
    .i_wdata_valid  (wdata_valid),
    .o_wdata_accept (wdata_accept),
    .i_wdata        (wdata),
    .i_wdata_last   (wdata_last),
    .o_resp_valid   (resp_valid),
    .i_resp_accept  (resp_accept),
    .o_resp_kind    (resp_kind),
    .o_resp_id      (resp_id),
    .o_resp_error   (resp_error),
    .o_resp_data    (resp_data),
    .o_resp_last    (resp_last)
  );

  // ##############################
  // checking helpers
  // ##############################
  task automatic compare_value(input string name, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_in_time(input bit ok, input string what);
    assert (ok) else begin
      $display("timed out at t=%0t while waiting for %s", $time, what);
      errors++;
    end
  endtask

  // ##############################
  // bus drivers
  // ##############################
  // all drivers start and end right after a rising edge
  task automatic send_command(input corebus_cmd_e kind, input logic [ID_WIDTH-1:0] id,
                              input logic [ADDR_WIDTH-1:0] addr,
                              input logic [LEN_WIDTH-1:0] len);
    int waited;
    bit taken;
    waited = 0;
    taken  = 1'b0;
    cmd_valid <= 1'b1;
    cmd_kind  <= kind;
    cmd_id    <= id;
    cmd_addr  <= addr;
    cmd_len   <= len;
    while (!taken && waited < TIMEOUT) begin
      @(posedge clk);
      taken = cmd_accept;  // value seen at the edge decides the transfer
      waited++;
    end
    cmd_valid <= 1'b0;
    expect_in_time(taken, "o_cmd_accept");
  endtask

  task automatic send_write_data(input int beats);
    int  i;
    int  waited;
    bit  taken;
    for (i = 0; i < beats; i++) begin
      waited = 0;
      taken  = 1'b0;
      wdata_valid <= 1'b1;
      wdata       <= wr_buf[i];
      wdata_last  <= (i == beats - 1);
      while (!taken && waited < TIMEOUT) begin
        @(posedge clk);
        taken = wdata_accept;
        waited++;
      end
      expect_in_time(taken, "o_wdata_accept");
    end
    wdata_valid <= 1'b0;
    wdata_last  <= 1'b0;
  endtask

  // writes fresh random data and updates the memory model when the address is mapped
  task automatic write_burst(input corebus_cmd_e kind, input logic [ID_WIDTH-1:0] id,
                             input int addr, input int beats);
    int i;
    for (i = 0; i < beats; i++) begin
      wr_buf[i] = $random(seed);
    end
    send_command(kind, id, ADDR_WIDTH'(addr), LEN_WIDTH'(beats - 1));
    send_write_data(beats);
    if (addr < SRAM_DEPTH) begin
      for (i = 0; i < beats; i++) begin
        ref_mem[(addr + i) % SRAM_DEPTH] = wr_buf[i];
      end
    end
  endtask

  // takes beats until one with last and can apply random back-pressure
  task automatic collect_response(input bit random_accept, input bit check_stall);
    int idle;
    int r;
    bit done;
    idle  = 0;
    done  = 1'b0;
    n_got = 0;
    r = $random(seed);
    resp_accept <= random_accept ? r[0] : 1'b1;
    while (!done && idle < TIMEOUT) begin
      @(posedge clk);
      if (check_stall) begin
        compare_value("o_cmd_accept", cmd_accept, 1'b0);  // next command must wait
      end
      if (resp_valid && resp_accept) begin
        if (n_got < 8) begin
          got_kind[n_got] = resp_kind;
          got_id[n_got]   = resp_id;
          got_err[n_got]  = resp_error;
          got_data[n_got] = resp_data;
          got_last[n_got] = resp_last;
        end
        n_got++;
        done = resp_last;
        idle = 0;
      end
      else begin
        idle++;
      end
      r = $random(seed);
      resp_accept <= (random_accept && !done) ? r[0] : !done;
    end
    resp_accept <= 1'b0;
    expect_in_time(done, "a response beat with o_resp_last");
  endtask

  task automatic expect_silence(input int cycles);
    bit seen;
    seen = 1'b0;
    resp_accept <= 1'b1;
    repeat (cycles) begin
      @(posedge clk);
      seen |= resp_valid;
    end
    resp_accept <= 1'b0;
    assert (!seen) else begin
      $display("a response appeared at t=%0t where none was expected", $time);
      errors++;
    end
  endtask

  task automatic wait_cmd_ready();
    int waited;
    bit ready;
    waited = 0;
    ready  = 1'b0;
    while (!ready && waited < TIMEOUT) begin
      @(posedge clk);
      ready = cmd_accept;
      waited++;
    end
    expect_in_time(ready, "o_cmd_accept to return high");
  endtask

  // ##############################
  // expected responses
  // ##############################
  task automatic check_read_beats(input logic [ID_WIDTH-1:0] id, input int addr,
                                  input int beats, input bit error);
    int i;
    compare_value("read beat count", n_got, beats);
    for (i = 0; i < beats && i < n_got && i < 8; i++) begin
      compare_value("o_resp_kind", got_kind[i], RESP_DATA);
      compare_value("o_resp_id", got_id[i], id);
      compare_value("o_resp_error", got_err[i], error);
      if (error) begin
        compare_value("o_resp_data", got_data[i], ERROR_DATA);
      end
      else begin
        compare_value("o_resp_data", got_data[i], ref_mem[(addr + i) % SRAM_DEPTH]);
      end
      compare_value("o_resp_last", got_last[i], i == beats - 1);
    end
  endtask

  task automatic check_plain_response(input logic [ID_WIDTH-1:0] id, input bit error);
    compare_value("response count", n_got, 1);
    compare_value("o_resp_kind", got_kind[0], RESP_PLAIN);
    compare_value("o_resp_id", got_id[0], id);
    compare_value("o_resp_error", got_err[0], error);
    compare_value("o_resp_last", got_last[0], 1'b1);
  endtask

  task automatic check_reset_outputs();
    compare_value("o_cmd_accept", cmd_accept, 1'b1);
    compare_value("o_resp_valid", resp_valid, 1'b0);
    compare_value("o_wdata_accept", wdata_accept, 1'b0);
  endtask

  // ##############################
  // directed tests
  // ##############################
  task automatic np_write_and_read_back();
    write_burst(CMD_WRITE_NP, 4'h3, 4, 4);
    collect_response(1'b0, 1'b0);
    check_plain_response(4'h3, 1'b0);
    send_command(CMD_READ, 4'h5, 16'd4, 3'd3);
    collect_response(1'b0, 1'b0);
    check_read_beats(4'h5, 4, 4, 1'b0);
  endtask

  task automatic unmapped_read();
    send_command(CMD_READ, 4'h9, ADDR_WIDTH'(SRAM_DEPTH), 3'd5);  // first unmapped word
    collect_response(1'b0, 1'b0);
    check_read_beats(4'h9, SRAM_DEPTH, 6, 1'b1);
  endtask

  task automatic unmapped_np_write();
    write_burst(CMD_WRITE_NP, 4'hc, 16'h8000, 3);
    collect_response(1'b0, 1'b0);
    check_plain_response(4'hc, 1'b1);
  endtask

  task automatic posted_traffic_silent();
    // low address bits alias words 4 and 5, so a wrong route would show in the read
    write_burst(CMD_WRITE, 4'h1, 16'hff04, 2);
    send_command(CMD_MESSAGE, 4'h2, 16'h1234, 3'd0);
    expect_silence(20);
    send_command(CMD_READ, 4'h6, 16'd4, 3'd3);
    collect_response(1'b0, 1'b0);
    check_read_beats(4'h6, 4, 4, 1'b0);
  endtask

  task automatic read_under_backpressure();
    write_burst(CMD_WRITE, 4'h7, 60, 8);  // runs past the top of the memory
    resp_accept <= 1'b0;
    send_command(CMD_READ, 4'ha, 16'd60, 3'd7);
    // a message parked in the command slice shows the stall on o_cmd_accept
    send_command(CMD_MESSAGE, 4'hb, 16'h4000, 3'd0);
    collect_response(1'b1, 1'b1);
    check_read_beats(4'ha, 60, 8, 1'b0);
    wait_cmd_ready();
    expect_silence(10);
  endtask

  initial begin
    rst_n       <= 1'b0;
    cmd_valid   <= 1'b0;
    cmd_kind    <= '0;
    cmd_id      <= '0;
    cmd_addr    <= '0;
    cmd_len     <= '0;
    wdata_valid <= 1'b0;
    wdata       <= '0;
    wdata_last  <= 1'b0;
    resp_accept <= 1'b0;
    repeat (5) @(posedge clk);
    check_reset_outputs();   // in the middle of the reset pulse
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_reset_outputs();
    @(posedge clk);
    check_reset_outputs();

    np_write_and_read_back();
    unmapped_read();
    unmapped_np_write();
    posted_traffic_silent();
    read_under_backpressure();

    repeat (2) @(posedge clk);
    $display("tb_corebus_subsystem finished with %0d errors", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end
    else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
src/corebus_pkg.sv
src/corebus_if.sv
src/corebus_slicer.sv
src/corebus_decoder.sv
src/corebus_sram_target.sv
src/corebus_dummy_target.sv
src/corebus_response_mux.sv
src/corebus_subsystem.sv
test/tb_corebus_subsystem.sv
